// File: src/vid_pkg.sv
// Shared widths, register map and mode bits for the video timing generator
// Imported by every RTL block that touches positions or the register bus
package vid_pkg;

	// Counter and bus widths
	localparam int HPOS_W = 11;
	localparam int VPOS_W = 11;
	localparam int DATA_W = 12;
	localparam int ADDR_W = 4;

	typedef logic [HPOS_W-1:0] hpos_t;
	typedef logic [VPOS_W-1:0] vpos_t;
	typedef logic [DATA_W-1:0] rdata_t;
	typedef logic [DATA_W-1:0] wdata_t;
	typedef logic [ADDR_W-1:0] reg_addr_t;

	// Write side register map
	localparam reg_addr_t ADDR_MODE = 4'd0;
	localparam reg_addr_t ADDR_HP   = 4'd1;
	localparam reg_addr_t ADDR_HBB  = 4'd2;
	localparam reg_addr_t ADDR_HBE  = 4'd3;
	localparam reg_addr_t ADDR_HS   = 4'd4;
	localparam reg_addr_t ADDR_HDB  = 4'd5;
	localparam reg_addr_t ADDR_HDE  = 4'd6;
	localparam reg_addr_t ADDR_VP   = 4'd7;
	localparam reg_addr_t ADDR_VBB  = 4'd8;
	localparam reg_addr_t ADDR_VBE  = 4'd9;
	localparam reg_addr_t ADDR_VS   = 4'd10;
	localparam reg_addr_t ADDR_VDB  = 4'd11;
	localparam reg_addr_t ADDR_VDE  = 4'd12;
	// Highest write address in use
	localparam reg_addr_t ADDR_VI   = 4'd13;

	// Read side map
	localparam reg_addr_t RD_HC  = 4'd0;
	localparam reg_addr_t RD_VC  = 4'd1;
	localparam reg_addr_t RD_LPH = 4'd2;
	localparam reg_addr_t RD_LPV = 4'd3;

	// Mode register bits
	localparam int MODE_VID_EN = 0;

endpackage

// File: src/vid_timing_if.sv
// Programmed compare values, from the register file out to the counters
// The register file drives everything, each counter block reads its own subset
interface vid_timing_if;
	import vid_pkg::*;

	logic  vid_en;
	// Horizontal compare values
	hpos_t h_period;
	hpos_t h_blank_begin;
	hpos_t h_blank_end;
	hpos_t h_sync_start;
	hpos_t h_disp_begin;
	hpos_t h_disp_end;
	// Vertical compare values
	vpos_t v_period;
	vpos_t v_blank_begin;
	vpos_t v_blank_end;
	vpos_t v_sync_start;
	vpos_t v_disp_begin;
	vpos_t v_disp_end;
	vpos_t v_int_line;

	modport regs (
		output vid_en, h_period, h_blank_begin, h_blank_end, h_sync_start,
			h_disp_begin, h_disp_end, v_period, v_blank_begin, v_blank_end,
			v_sync_start, v_disp_begin, v_disp_end, v_int_line
	);
	modport hcount (input vid_en, h_period, h_blank_begin, h_blank_end, h_sync_start);
	// Interrupt needs the horizontal display end too
	modport vcount (
		input vid_en, v_period, v_blank_begin, v_blank_end, v_sync_start, v_int_line,
			h_disp_end
	);
	modport display (input vid_en, h_disp_begin, h_disp_end, v_disp_begin, v_disp_end);

endinterface

// File: src/vid_regs.sv
// Mode and timing registers written by single-cycle strobes
// Also muxes counter and light-pen state onto the combinational read bus
module vid_regs (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic               reg_wr,
	input  vid_pkg::reg_addr_t reg_addr,
	input  vid_pkg::wdata_t    reg_wdata,
	input  vid_pkg::reg_addr_t rd_addr,
	input  vid_pkg::hpos_t     hc,
	input  vid_pkg::vpos_t     vc,
	input  logic               field,
	input  vid_pkg::hpos_t     lp_h,
	input  vid_pkg::vpos_t     lp_v,
	input  logic               lp_event,
	vid_timing_if.regs         cfg,
	output vid_pkg::rdata_t    rd_data
);
	import vid_pkg::*;

	// Register writes, visible the cycle after the strobe
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cfg.vid_en        <= 1'b0;
			cfg.h_period      <= '0;
			cfg.h_blank_begin <= '0;
			cfg.h_blank_end   <= '0;
			cfg.h_sync_start  <= '0;
			cfg.h_disp_begin  <= '0;
			cfg.h_disp_end    <= '0;
			cfg.v_period      <= '0;
			cfg.v_blank_begin <= '0;
			cfg.v_blank_end   <= '0;
			cfg.v_sync_start  <= '0;
			cfg.v_disp_begin  <= '0;
			cfg.v_disp_end    <= '0;
			cfg.v_int_line    <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				// Only the enable bit of the mode word is implemented
				ADDR_MODE: cfg.vid_en        <= reg_wdata[MODE_VID_EN];
				ADDR_HP:   cfg.h_period      <= hpos_t'(reg_wdata);
				ADDR_HBB:  cfg.h_blank_begin <= hpos_t'(reg_wdata);
				ADDR_HBE:  cfg.h_blank_end   <= hpos_t'(reg_wdata);
				ADDR_HS:   cfg.h_sync_start  <= hpos_t'(reg_wdata);
				ADDR_HDB:  cfg.h_disp_begin  <= hpos_t'(reg_wdata);
				ADDR_HDE:  cfg.h_disp_end    <= hpos_t'(reg_wdata);
				ADDR_VP:   cfg.v_period      <= vpos_t'(reg_wdata);
				ADDR_VBB:  cfg.v_blank_begin <= vpos_t'(reg_wdata);
				ADDR_VBE:  cfg.v_blank_end   <= vpos_t'(reg_wdata);
				ADDR_VS:   cfg.v_sync_start  <= vpos_t'(reg_wdata);
				ADDR_VDB:  cfg.v_disp_begin  <= vpos_t'(reg_wdata);
				ADDR_VDE:  cfg.v_disp_end    <= vpos_t'(reg_wdata);
				ADDR_VI:   cfg.v_int_line    <= vpos_t'(reg_wdata);
				default: ;
			endcase
		end
	end

	// Readback, zero-extended to the bus width
	always_comb begin
		case (rd_addr)
			RD_HC:   rd_data = rdata_t'(hc);
			// Field bit rides in the top bit
			RD_VC:   rd_data = {field, vc};
			// Event flag rides in the top bit
			RD_LPH:  rd_data = {lp_event, lp_h};
			RD_LPV:  rd_data = rdata_t'(lp_v);
			default: rd_data = '0;
		endcase
	end

	// Bus master must stay inside the implemented write map
	a_wr_addr_valid: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		reg_wr |-> (reg_addr <= ADDR_VI)
	);

endmodule

// File: src/vid_hcount.sv
// Horizontal pixel counter with end-of-line detect
// Keeps the horizontal blank and sync flags from the programmed compares
module vid_hcount (
	input  logic           sys_clk,
	input  logic           resetl,
	vid_timing_if.hcount   cfg,
	output vid_pkg::hpos_t hc,
	output logic           line_end,
	output logic           hblank,
	output logic           hsync
);
	import vid_pkg::*;

	logic hbb_eq;
	logic hbe_eq;
	logic hs_eq;

	// Last pixel of the line, only counts while enabled
	assign line_end = (hc == cfg.h_period) & cfg.vid_en;

	assign hbb_eq = (hc == cfg.h_blank_begin);
	assign hbe_eq = (hc == cfg.h_blank_end);
	assign hs_eq  = (hc == cfg.h_sync_start);

	// Pixel counter
	always_ff @(posedge sys_clk) begin
		if (!resetl || !cfg.vid_en) begin
			hc <= '0;
		end else if (line_end) begin
			// Line is h_period+1 clocks long
			hc <= '0;
		end else begin
			hc <= hc + hpos_t'(1);
		end
	end

	// Set/clear flags, one edge behind their compares
	always_ff @(posedge sys_clk) begin
		if (!resetl || !cfg.vid_en) begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
		end else begin
			// While clear look for set, while set look for clear
			if (hblank) begin
				hblank <= ~hbe_eq;
			end else begin
				hblank <= hbb_eq;
			end
			// Sync ends with the line
			if (hsync) begin
				hsync <= ~line_end;
			end else begin
				hsync <= hs_eq;
			end
		end
	end

	// Disable drops both flags by the next cycle
	a_flags_off: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		!cfg.vid_en |=> (!hblank && !hsync)
	);

endmodule

// File: src/vid_vcount.sv
// Vertical line counter with field bit and end-of-field detect
// Keeps vertical blank and sync flags and raises the one-cycle vertical interrupt
module vid_vcount (
	input  logic           sys_clk,
	input  logic           resetl,
	input  logic           line_end,
	input  vid_pkg::hpos_t hc,
	vid_timing_if.vcount   cfg,
	output vid_pkg::vpos_t vc,
	output logic           field,
	output logic           field_end,
	output logic           vblank,
	output logic           vsync,
	output logic           vint
);
	import vid_pkg::*;

	logic vbb_eq;
	logic vbe_eq;
	logic vs_eq;
	logic vint_hit;

	// Last pixel of the last line
	assign field_end = line_end & (vc == cfg.v_period);

	assign vbb_eq = (vc == cfg.v_blank_begin);
	assign vbe_eq = (vc == cfg.v_blank_end);
	assign vs_eq  = (vc == cfg.v_sync_start);

	// Interrupt position, line and pixel together
	assign vint_hit = (vc == cfg.v_int_line) & (hc == cfg.h_disp_end);

	// Line counter and field toggle
	always_ff @(posedge sys_clk) begin
		if (!resetl || !cfg.vid_en) begin
			vc    <= '0;
			field <= 1'b0;
		end else if (field_end) begin
			vc    <= '0;
			field <= ~field;
		end else if (line_end) begin
			vc <= vc + vpos_t'(1);
		end
	end

	// Vertical flags and interrupt pulse
	always_ff @(posedge sys_clk) begin
		if (!resetl || !cfg.vid_en) begin
			vblank <= 1'b0;
			vsync  <= 1'b0;
			vint   <= 1'b0;
		end else begin
			// Blank compares act on any cycle of the line
			if (vblank) begin
				vblank <= ~vbe_eq;
			end else begin
				vblank <= vbb_eq;
			end
			// Sync runs until the field wraps
			if (vsync) begin
				vsync <= ~field_end;
			end else begin
				vsync <= vs_eq;
			end
			vint <= vint_hit;
		end
	end

	// One pixel match per line, so the pulse never stretches
	a_vint_pulse: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		vint |=> !vint
	);

endmodule

// File: src/vid_display.sv
// Display window, line-start strobe and display-active level
// Swaps the ping-pong line buffers at the start of every displayed line
module vid_display (
	input  logic           sys_clk,
	input  logic           resetl,
	input  vid_pkg::hpos_t hc,
	input  vid_pkg::vpos_t vc,
	vid_timing_if.display  cfg,
	output logic           line_start,
	output logic           disp_active,
	output logic           lba_active,
	output logic           lbb_active,
	output logic           lbuf_sel
);
	import vid_pkg::*;

	logic vwin;
	logic hde_eq;

	assign hde_eq = (hc == cfg.h_disp_end);

	always_ff @(posedge sys_clk) begin
		if (!resetl || !cfg.vid_en) begin
			vwin        <= 1'b0;
			line_start  <= 1'b0;
			disp_active <= 1'b0;
			lbuf_sel    <= 1'b0;
		end else begin
			// Vertical window between begin and end lines
			if (vwin) begin
				vwin <= (vc != cfg.v_disp_end);
			end else begin
				vwin <= (vc == cfg.v_disp_begin);
			end
			// Strobe at the first displayed pixel
			line_start <= vwin & (hc == cfg.h_disp_begin);
			// Active from the strobe to the end pixel
			if (disp_active) begin
				disp_active <= ~hde_eq;
			end else begin
				disp_active <= line_start;
			end
			// Next line goes to the other buffer
			lbuf_sel <= lbuf_sel ^ line_start;
		end
	end

	assign lba_active = disp_active & lbuf_sel;
	assign lbb_active = disp_active & ~lbuf_sel;

	a_lbuf_excl: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		!(lba_active && lbb_active)
	);

endmodule

// File: src/vid_lightpen.sv
// Light-pen input synchroniser and beam position latch
// Event flag marks a hit in the current field and clears at field end
module vid_lightpen #(
	parameter int LP_SYNC_STAGES = 2
) (
	input  logic           sys_clk,
	input  logic           resetl,
	input  logic           lp,
	input  logic           field_end,
	input  vid_pkg::hpos_t hc,
	input  vid_pkg::vpos_t vc,
	output vid_pkg::hpos_t lp_h,
	output vid_pkg::vpos_t lp_v,
	output logic           lp_event
);
	import vid_pkg::*;

	logic [LP_SYNC_STAGES-1:0] lp_sync;
	logic                      lp_prev;
	logic                      lp_rise;

	// Rising edge seen at the last synchroniser stage
	assign lp_rise = lp_sync[LP_SYNC_STAGES-1] & ~lp_prev;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lp_sync  <= '0;
			lp_prev  <= 1'b0;
			lp_h     <= '0;
			lp_v     <= '0;
			lp_event <= 1'b0;
		end else begin
			lp_sync <= {lp_sync[LP_SYNC_STAGES-2:0], lp};
			lp_prev <= lp_sync[LP_SYNC_STAGES-1];
			// Beam position at the hit
			if (lp_rise) begin
				lp_h <= hc;
				lp_v <= vc;
			end
			// Hit wins while clear, field end wins while set
			if (lp_event) begin
				lp_event <= ~field_end;
			end else begin
				lp_event <= lp_rise;
			end
		end
	end

endmodule

// File: src/vid_top.sv
// Video timing generator top level with plain ports
// Register bus in, blank, sync, interrupt and display strobes out
module vid_top #(
	parameter int LP_SYNC_STAGES = 2
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic               reg_wr,
	input  vid_pkg::reg_addr_t reg_addr,
	input  vid_pkg::wdata_t    reg_wdata,
	input  vid_pkg::reg_addr_t rd_addr,
	input  logic               lp,
	output vid_pkg::rdata_t    rd_data,
	output logic               hblank,
	output logic               vblank,
	output logic               blank,
	output logic               hsync,
	output logic               vsync,
	output logic               vint,
	output logic               line_start,
	output logic               disp_active,
	output logic               lba_active,
	output logic               lbb_active
);
	import vid_pkg::*;

	hpos_t hc;
	vpos_t vc;
	logic  line_end;
	logic  field;
	logic  field_end;
	hpos_t lp_h;
	vpos_t lp_v;
	logic  lp_event;

	// Programmed compare values
	vid_timing_if u_cfg ();

	vid_regs u_regs (
		.sys_clk(sys_clk), .resetl(resetl),
		.reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
		.rd_addr(rd_addr), .hc(hc), .vc(vc), .field(field),
		.lp_h(lp_h), .lp_v(lp_v), .lp_event(lp_event),
		.cfg(u_cfg.regs), .rd_data(rd_data)
	);

	vid_hcount u_hcount (
		.sys_clk(sys_clk), .resetl(resetl), .cfg(u_cfg.hcount),
		.hc(hc), .line_end(line_end), .hblank(hblank), .hsync(hsync)
	);

	vid_vcount u_vcount (
		.sys_clk(sys_clk), .resetl(resetl), .line_end(line_end), .hc(hc),
		.cfg(u_cfg.vcount), .vc(vc), .field(field), .field_end(field_end),
		.vblank(vblank), .vsync(vsync), .vint(vint)
	);

	// Buffer select itself stays internal
	vid_display u_display (
		.sys_clk(sys_clk), .resetl(resetl), .hc(hc), .vc(vc),
		.cfg(u_cfg.display), .line_start(line_start), .disp_active(disp_active),
		.lba_active(lba_active), .lbb_active(lbb_active), .lbuf_sel()
	);

	vid_lightpen #(
		.LP_SYNC_STAGES(LP_SYNC_STAGES)
	) u_lightpen (
		.sys_clk(sys_clk), .resetl(resetl), .lp(lp), .field_end(field_end),
		.hc(hc), .vc(vc), .lp_h(lp_h), .lp_v(lp_v), .lp_event(lp_event)
	);

	// Combined blank
	assign blank = hblank | vblank;

endmodule

// File: verification/vid_tb.sv
// Self-checking testbench for the video timing generator
// Programs a small raster, mirrors the beam in a reference model and compares every cycle
module vid_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import vid_pkg::*;

	localparam int LP_STAGES = 2;
	localparam int FIELD_TIMEOUT = 2000;
	localparam int LINE_TIMEOUT = 100;

	// Model of the beam, flags and light-pen latch
	typedef struct packed {
		hpos_t hc;
		vpos_t vc;
		logic field;
		logic hblank, hsync, vblank, vsync, vint;
		logic vwin, line_start, disp_active, lbuf_sel;
		logic [LP_STAGES-1:0] lp_sync;
		logic lp_prev;
		hpos_t lp_h;
		vpos_t lp_v;
		logic lp_event;
		// Field wrapped at this edge
		logic wrapped;
	} model_t;

	logic sys_clk;
	logic resetl;
	logic reg_wr;
	reg_addr_t reg_addr;
	wdata_t reg_wdata;
	reg_addr_t rd_addr;
	logic lp;
	rdata_t rd_data;
	logic hblank, vblank, blank, hsync, vsync, vint;
	logic line_start, disp_active, lba_active, lbb_active;

	model_t m;
	wdata_t cfg_v [16];
	bit model_valid = 1'b0;
	bit lp_random = 1'b0;
	int rd_sel = 0;
	int fields_seen = 0;
	int vint_cnt = 0;
	// Bit i of the flag vectors below
	string flag_names [10] = '{"lbb_active", "lba_active", "disp_active", "line_start",
		"vint", "vsync", "hsync", "blank", "vblank", "hblank"};

	vid_top #(.LP_SYNC_STAGES(LP_STAGES)) u_vid_top (
		.sys_clk(sys_clk), .resetl(resetl), .reg_wr(reg_wr), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .rd_addr(rd_addr), .lp(lp), .rd_data(rd_data),
		.hblank(hblank), .vblank(vblank), .blank(blank), .hsync(hsync), .vsync(vsync),
		.vint(vint), .line_start(line_start), .disp_active(disp_active),
		.lba_active(lba_active), .lbb_active(lbb_active)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	function automatic hpos_t hreg(reg_addr_t a);
		return hpos_t'(cfg_v[a]);
	endfunction

	function automatic vpos_t vreg(reg_addr_t a);
		return vpos_t'(cfg_v[a]);
	endfunction

	// Next model state from the current one and the programmed values
	function automatic model_t next_state(model_t s, logic lp_in);
		model_t n;
		logic en;
		logic le;
		logic fe;
		logic rise;
		en = cfg_v[ADDR_MODE][MODE_VID_EN];
		le = en && (s.hc == hreg(ADDR_HP));
		fe = le && (s.vc == vreg(ADDR_VP));
		rise = s.lp_sync[LP_STAGES-1] && !s.lp_prev;
		n = '0;
		// Pen logic runs whether or not video is on
		n.lp_sync = {s.lp_sync[LP_STAGES-2:0], lp_in};
		n.lp_prev = s.lp_sync[LP_STAGES-1];
		n.lp_h = rise ? s.hc : s.lp_h;
		n.lp_v = rise ? s.vc : s.lp_v;
		n.lp_event = s.lp_event ? !fe : rise;
		n.wrapped = fe;
		if (en) begin
			n.hc = le ? '0 : s.hc + hpos_t'(1);
			n.vc = fe ? '0 : (le ? s.vc + vpos_t'(1) : s.vc);
			n.field = s.field ^ fe;
			// Set compare while clear, clear compare while set
			n.hblank = s.hblank ? (s.hc != hreg(ADDR_HBE)) : (s.hc == hreg(ADDR_HBB));
			n.hsync = s.hsync ? !le : (s.hc == hreg(ADDR_HS));
			n.vblank = s.vblank ? (s.vc != vreg(ADDR_VBE)) : (s.vc == vreg(ADDR_VBB));
			n.vsync = s.vsync ? !fe : (s.vc == vreg(ADDR_VS));
			n.vint = (s.vc == vreg(ADDR_VI)) && (s.hc == hreg(ADDR_HDE));
			n.vwin = s.vwin ? (s.vc != vreg(ADDR_VDE)) : (s.vc == vreg(ADDR_VDB));
			n.line_start = s.vwin && (s.hc == hreg(ADDR_HDB));
			n.disp_active = s.disp_active ? (s.hc != hreg(ADDR_HDE)) : s.line_start;
			n.lbuf_sel = s.lbuf_sel ^ s.line_start;
		end
		return n;
	endfunction

	function automatic rdata_t expected_rd(reg_addr_t a);
		case (a)
			RD_HC:   return {1'b0, m.hc};
			RD_VC:   return {m.field, m.vc};
			RD_LPH:  return {m.lp_event, m.lp_h};
			RD_LPV:  return {1'b0, m.lp_v};
			default: return '0;
		endcase
	endfunction

	function automatic logic [9:0] expected_flags();
		return {m.hblank, m.vblank, m.hblank | m.vblank, m.hsync, m.vsync, m.vint,
			m.line_start, m.disp_active, m.disp_active & m.lbuf_sel,
			m.disp_active & ~m.lbuf_sel};
	endfunction

	task automatic report_mismatch(string sig, rdata_t got, rdata_t exp);
		$display("[ERROR] %0d ns %s: got %h, expected %h", $time, sig, got, exp);
		$display("Done: errors found");
		$fatal(1, "Mismatch on %s", sig);
	endtask

	task automatic timeout_fail(string what);
		$display("Timed out while waiting for %s", what);
		$display("Done: errors found");
		$fatal(1, "Timeout");
	endtask

	// Model steps on the same edge as the DUT and writes land after the step
	always @(posedge sys_clk) begin
		if (!resetl) begin
			m = '0;
			cfg_v = '{default: '0};
		end else begin
			m = next_state(m, lp);
			if (m.wrapped) begin
				fields_seen++;
			end
			if (reg_wr) begin
				cfg_v[reg_addr] = reg_wdata;
			end
		end
		model_valid = 1'b1;
	end

	// Outputs are settled at the falling edge
	always @(negedge sys_clk) begin
		logic [9:0] got;
		logic [9:0] exp;
		if (model_valid) begin
			got = {hblank, vblank, blank, hsync, vsync, vint,
				line_start, disp_active, lba_active, lbb_active};
			exp = expected_flags();
			assert (!(lba_active && lbb_active))
			else report_mismatch("lba_active and lbb_active", rdata_t'(1), rdata_t'(0));
			for (int i = 0; i < 10; i++) begin
				assert (got[i] === exp[i])
				else report_mismatch(flag_names[i], rdata_t'(got[i]), rdata_t'(exp[i]));
			end
			assert (rd_data === expected_rd(rd_addr))
			else report_mismatch("rd_data", rd_data, expected_rd(rd_addr));
			if (vint === 1'b1) begin
				vint_cnt++;
			end
		end
	end

	// One cycle with inputs changed just after the edge
	task automatic tick();
		@(posedge sys_clk);
		#2;
		rd_addr = reg_addr_t'(rd_sel);
		// Walk the read map plus one unused address
		rd_sel = (rd_sel == 4) ? 0 : rd_sel + 1;
		lp = lp_random && ($urandom_range(0, 23) == 0);
	endtask

	task automatic write_reg(reg_addr_t a, wdata_t d);
		tick();
		reg_wr = 1'b1;
		reg_addr = a;
		reg_wdata = d;
		tick();
		reg_wr = 1'b0;
	endtask

	task automatic wait_fields(int target);
		int cycles;
		cycles = 0;
		while (fields_seen < target && cycles < FIELD_TIMEOUT) begin
			tick();
			cycles++;
		end
		if (fields_seen < target) begin
			timeout_fail("field end");
		end
	endtask

	task automatic wait_hc(hpos_t pos);
		int cycles;
		cycles = 0;
		while (m.hc != pos && cycles < LINE_TIMEOUT) begin
			tick();
			cycles++;
		end
		if (m.hc != pos) begin
			timeout_fail("horizontal position");
		end
	endtask

	initial begin
		void'($urandom(16));
		resetl = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		rd_addr = '0;
		lp = 1'b0;
		repeat (2) @(posedge sys_clk);
		#2;
		resetl = 1'b1;
		// Video still off so everything reads zero
		repeat (10) tick();
		// 20 pixel by 10 line raster with the enable written last
		write_reg(ADDR_HP, 12'd19);
		write_reg(ADDR_HBB, 12'd15);
		write_reg(ADDR_HBE, 12'd3);
		write_reg(ADDR_HS, 12'd17);
		write_reg(ADDR_HDB, 12'd5);
		write_reg(ADDR_HDE, 12'd13);
		write_reg(ADDR_VP, 12'd9);
		write_reg(ADDR_VBB, 12'd8);
		write_reg(ADDR_VBE, 12'd1);
		write_reg(ADDR_VS, 12'd9);
		write_reg(ADDR_VDB, 12'd2);
		write_reg(ADDR_VDE, 12'd7);
		write_reg(ADDR_VI, 12'd4);
		write_reg(ADDR_MODE, 12'd1);
		wait_fields(2);
		// Pen hits over two more fields
		lp_random = 1'b1;
		wait_fields(4);
		lp_random = 1'b0;
		// Disable in the middle of a line
		wait_hc(hpos_t'(7));
		write_reg(ADDR_MODE, 12'd0);
		repeat (10) tick();
		// One interrupt per completed field
		assert (vint_cnt == fields_seen)
		else report_mismatch("vint count", rdata_t'(vint_cnt), rdata_t'(fields_seen));
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: tb.f
src/vid_pkg.sv
src/vid_timing_if.sv
src/vid_regs.sv
src/vid_hcount.sv
src/vid_vcount.sv
src/vid_display.sv
src/vid_lightpen.sv
src/vid_top.sv
verification/vid_tb.sv

// File: Makefile
# Verilator build and run of the video timing generator testbench
VERILATOR ?= verilator
TOP       ?= vid_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
